// ==== src/coproc_defines.svh ====
//--------------------
// Frame geometry for the matrix-vector coprocessor
// COLS must stay a power of two
// The column index is taken from the low bits of the A address
// ACC_W must hold COLS * 255 * 255
//--------------------
`ifndef COPROC_DEFINES_SVH
`define COPROC_DEFINES_SVH

// Rows of A and words of RES
`define COPROC_ROWS 8
// Columns of A and length of B
`define COPROC_COLS 4
// One operand byte
`define COPROC_ELEM_W 8
// Unsigned row sum
`define COPROC_ACC_W 18
// Stream word on both ports
`define COPROC_AXIS_W 32
// Registered read of every RAM
`define COPROC_RAM_LAT 1

`endif

// ==== src/coproc_pkg.sv ====
//--------------------
// Shared types of the coprocessor
// Sizes follow the dimension macros
//--------------------
`default_nettype none
`include "coproc_defines.svh"

package coproc_pkg;

	typedef logic [`COPROC_ELEM_W-1:0] elem_t;                            // Operand byte
	typedef logic [`COPROC_ACC_W-1:0] acc_t;                              // Row sum
	typedef logic [`COPROC_AXIS_W-1:0] axis_data_t;                       // Stream word
	typedef logic [$clog2(`COPROC_ROWS*`COPROC_COLS)-1:0] a_addr_t;
	typedef logic [$clog2(`COPROC_COLS)-1:0] b_addr_t;
	typedef logic [$clog2(`COPROC_ROWS)-1:0] res_addr_t;
	// Input beat count up to the full frame
	typedef logic [$clog2(`COPROC_ROWS*`COPROC_COLS+`COPROC_COLS+1)-1:0] frame_cnt_t;

	typedef enum logic [1:0] {
		IDLE,
		READ_INPUTS,
		COMPUTE,
		WRITE_OUTPUTS
	} coproc_state_e;

	typedef struct packed {logic en; a_addr_t addr; elem_t data;} a_wr_t;
	typedef struct packed {logic en; b_addr_t addr; elem_t data;} b_wr_t;

	typedef struct packed {
		logic      valid;
		logic      first;  // Load instead of add
		logic      last;   // Row sum complete
		res_addr_t row;
	} mac_op_t;

	typedef struct packed {logic en; res_addr_t addr; acc_t data;} res_wr_t;
	typedef struct packed {logic valid; res_addr_t addr; logic last;} res_rd_t;

endpackage

`default_nettype wire

// ==== src/matrix_ram.sv ====
//--------------------
// Single clock RAM with one write and one read port
// Read data is registered and valid one cycle after rd_addr
// A read of the address being written returns the old word
// No reset on the contents
//--------------------
`timescale 1ns/1ps
`default_nettype none

module matrix_ram #(
	parameter int depth_bits = 5,
	parameter int width      = 8
) (
	input  logic                  ACLK,
	input  logic                  wr_en,
	input  logic [depth_bits-1:0] wr_addr,
	input  logic [width-1:0]      wr_data,
	input  logic [depth_bits-1:0] rd_addr,
	output logic [width-1:0]      rd_data
);

	logic [width-1:0] mem [2**depth_bits];  // Storage array

	always_ff @(posedge ACLK) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;  // Write lands at this edge
		end
	end

	// Registered read port
	always_ff @(posedge ACLK) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== src/dot_product_mac.sv ====
//--------------------
// Multiply-accumulate for one A row against B
// mac_op must be issued in the cycle its RAM addresses are issued
// Sums are unsigned with no overflow check
//--------------------
`timescale 1ns/1ps
`default_nettype none

module dot_product_mac (
	input  logic                ACLK,
	input  logic                ARESETN,
	input  coproc_pkg::mac_op_t mac_op,
	input  coproc_pkg::elem_t   a_data,
	input  coproc_pkg::elem_t   b_data,
	output coproc_pkg::res_wr_t res_wr
);

	coproc_pkg::mac_op_t op_q;     // Op aligned with RAM data
	coproc_pkg::acc_t    acc;      // Running row sum
	coproc_pkg::acc_t    product;
	coproc_pkg::acc_t    sum;

	// Byte by byte product widened to the sum width
	assign product = coproc_pkg::acc_t'(a_data) * coproc_pkg::acc_t'(b_data);
	assign sum     = (op_q.first ? '0 : acc) + product;  // First column restarts the row

	// One stage delay to match the RAM read latency
	always_ff @(posedge ACLK) begin
		if (!ARESETN) begin
			op_q      <= '0;
			res_wr.en <= 1'b0;
		end else begin
			op_q        <= mac_op;
			res_wr.en   <= op_q.valid && op_q.last;  // Row done
			res_wr.addr <= op_q.row;  // Row carried along with the op
			res_wr.data <= sum;
		end
	end

	always_ff @(posedge ACLK) begin
		if (op_q.valid) begin
			acc <= sum;
		end
	end

endmodule

`default_nettype wire

// ==== src/result_streamer.sv ====
//--------------------
// Two entry output buffer in front of M_AXIS
// Expects res_data one cycle after each res_rd request
// slot_free stays low while the frame's last word is still pending
//--------------------
`timescale 1ns/1ps
`default_nettype none

module result_streamer (
	input  logic                   ACLK,
	input  logic                   ARESETN,
	input  coproc_pkg::res_rd_t    res_rd,
	input  coproc_pkg::acc_t       res_data,
	output logic                   slot_free,
	output logic                   M_AXIS_TVALID,
	output coproc_pkg::axis_data_t M_AXIS_TDATA,
	output logic                   M_AXIS_TLAST,
	input  logic                   M_AXIS_TREADY
);

	logic             stage_valid;    // Read in flight
	logic             stage_last;
	coproc_pkg::acc_t fifo_data [2];
	logic             fifo_last [2];
	logic             wr_ptr;
	logic             rd_ptr;
	logic [1:0]       fifo_cnt;
	logic [1:0]       occ;            // Buffered plus in flight
	logic             last_pend;      // Final word not yet sent
	logic             pop;

	assign pop           = M_AXIS_TVALID && M_AXIS_TREADY;
	assign occ           = fifo_cnt + 2'(stage_valid);
	// Room for one more word, counting a pop this cycle
	assign slot_free     = ((occ < 2'd2) || pop) && (!last_pend || (pop && M_AXIS_TLAST));
	assign M_AXIS_TVALID = (fifo_cnt != 2'd0);
	assign M_AXIS_TDATA  = coproc_pkg::axis_data_t'(fifo_data[rd_ptr]);  // Zero extended
	assign M_AXIS_TLAST  = M_AXIS_TVALID && fifo_last[rd_ptr];

	always_ff @(posedge ACLK) begin
		if (!ARESETN) begin
			stage_valid <= 1'b0;
			wr_ptr      <= 1'b0;
			rd_ptr      <= 1'b0;
			fifo_cnt    <= 2'd0;
			last_pend   <= 1'b0;
		end else begin
			stage_valid <= res_rd.valid;
			if (stage_valid) wr_ptr <= ~wr_ptr;
			if (pop) rd_ptr <= ~rd_ptr;
			fifo_cnt <= fifo_cnt + 2'(stage_valid) - 2'(pop);
			if (res_rd.valid && res_rd.last) begin
				last_pend <= 1'b1;
			end else if (pop && M_AXIS_TLAST) begin
				last_pend <= 1'b0;                  // Frame handed off
			end
		end
	end

	always_ff @(posedge ACLK) begin
		stage_last <= res_rd.last;
		if (stage_valid) begin
			fifo_data[wr_ptr] <= res_data;          // RAM word arrives with the stage
			fifo_last[wr_ptr] <= stage_last;
		end
	end

endmodule

`default_nettype wire

// ==== src/coproc_ctrl.sv ====
//--------------------
// Frame sequencer of the coprocessor
// Fixed frame of A row-major then B with no input TLAST
// The producer must hold each beat until it transfers
// Only TDATA bits of one element width are stored
//--------------------
`timescale 1ns/1ps
`default_nettype none
`include "coproc_defines.svh"

module coproc_ctrl (
	input  logic                   ACLK,
	input  logic                   ARESETN,
	input  logic                   S_AXIS_TVALID,
	input  coproc_pkg::axis_data_t S_AXIS_TDATA,
	output logic                   S_AXIS_TREADY,
	output coproc_pkg::a_wr_t      a_wr,
	output coproc_pkg::b_wr_t      b_wr,
	output coproc_pkg::a_addr_t    a_rd_addr,
	output coproc_pkg::b_addr_t    b_rd_addr,
	output coproc_pkg::mac_op_t    mac_op,
	output coproc_pkg::res_rd_t    res_rd,
	input  logic                   slot_free
);

	localparam int a_size = `COPROC_ROWS * `COPROC_COLS;
	localparam int drain  = `COPROC_RAM_LAT + 1;  // RAM stage plus MAC output stage

	localparam coproc_pkg::frame_cnt_t a_words    = coproc_pkg::frame_cnt_t'(a_size);
	localparam coproc_pkg::frame_cnt_t last_beat  =
		coproc_pkg::frame_cnt_t'(a_size + `COPROC_COLS - 1);
	localparam coproc_pkg::frame_cnt_t last_cycle = coproc_pkg::frame_cnt_t'(a_size + drain - 1);
	localparam coproc_pkg::frame_cnt_t res_words  = coproc_pkg::frame_cnt_t'(`COPROC_ROWS);

	coproc_pkg::coproc_state_e state;
	coproc_pkg::frame_cnt_t    frame_cnt;  // Accepted input beats
	coproc_pkg::frame_cnt_t    issue_cnt;  // Compute cycles, then RES reads
	coproc_pkg::b_addr_t       col;
	logic                      s_xfer;

	assign s_xfer = (state == coproc_pkg::READ_INPUTS) && S_AXIS_TVALID && S_AXIS_TREADY;
	assign col    = coproc_pkg::b_addr_t'(issue_cnt);  // Low bits walk the columns

	// Operand write steering straight from the accepted beat
	always_comb begin
		a_wr.en   = s_xfer && (frame_cnt < a_words);
		a_wr.addr = coproc_pkg::a_addr_t'(frame_cnt);
		a_wr.data = coproc_pkg::elem_t'(S_AXIS_TDATA);
		b_wr.en   = s_xfer && (frame_cnt >= a_words);  // Tail of the frame is B
		b_wr.addr = coproc_pkg::b_addr_t'(frame_cnt - a_words);
		b_wr.data = coproc_pkg::elem_t'(S_AXIS_TDATA);
	end

	// One A/B read and one MAC op per compute cycle
	always_comb begin
		a_rd_addr    = coproc_pkg::a_addr_t'(issue_cnt);
		b_rd_addr    = col;
		mac_op.valid = (state == coproc_pkg::COMPUTE) && (issue_cnt < a_words);
		mac_op.first = (col == '0);
		mac_op.last  = (col == coproc_pkg::b_addr_t'(`COPROC_COLS - 1));
		mac_op.row   = coproc_pkg::res_addr_t'(issue_cnt >> $clog2(`COPROC_COLS));
	end

	// RES reads paced by the output buffer
	always_comb begin
		res_rd.valid = (state == coproc_pkg::WRITE_OUTPUTS) && (issue_cnt < res_words) && slot_free;
		res_rd.addr  = coproc_pkg::res_addr_t'(issue_cnt);
		res_rd.last  = (issue_cnt == res_words - 1'b1);  // Eighth word carries TLAST
	end

	always_ff @(posedge ACLK) begin
		if (!ARESETN) begin
			state         <= coproc_pkg::IDLE;
			S_AXIS_TREADY <= 1'b0;
			frame_cnt     <= '0;
			issue_cnt     <= '0;
		end else begin
			case (state)
				coproc_pkg::IDLE: begin
					frame_cnt <= '0;
					issue_cnt <= '0;
					if (S_AXIS_TVALID) begin
						state         <= coproc_pkg::READ_INPUTS;
						S_AXIS_TREADY <= 1'b1;  // Ready from the next cycle
					end
				end

				coproc_pkg::READ_INPUTS: begin
					S_AXIS_TREADY <= S_AXIS_TVALID;  // Ready trails valid by one cycle
					if (s_xfer) begin
						frame_cnt <= frame_cnt + 1'b1;
						if (frame_cnt == last_beat) begin
							// Full frame stored so stop accepting
							S_AXIS_TREADY <= 1'b0;
							state         <= coproc_pkg::COMPUTE;
							issue_cnt     <= '0;
						end
					end
				end

				coproc_pkg::COMPUTE: begin
					issue_cnt <= issue_cnt + 1'b1;
					if (issue_cnt == last_cycle) begin
						state     <= coproc_pkg::WRITE_OUTPUTS;  // Last row sum now in RES
						issue_cnt <= '0;
					end
				end

				coproc_pkg::WRITE_OUTPUTS: begin
					if (res_rd.valid) begin
						issue_cnt <= issue_cnt + 1'b1;
					end
					// slot_free returns high on the TLAST transfer
					if ((issue_cnt == res_words) && slot_free) begin
						state <= coproc_pkg::IDLE;
					end
				end

				default: begin
					state <= coproc_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/coproc_top.sv ====
//--------------------
// Matrix-vector coprocessor on two AXI-Stream ports
// One frame is A row-major then B, one byte per beat
// Emits one zero extended row sum per output beat with TLAST on the last
//--------------------
`timescale 1ns/1ps
`default_nettype none

module coproc_top (
	input  logic                   ACLK,
	input  logic                   ARESETN,
	input  logic                   S_AXIS_TVALID,
	input  coproc_pkg::axis_data_t S_AXIS_TDATA,
	output logic                   S_AXIS_TREADY,
	output logic                   M_AXIS_TVALID,
	output coproc_pkg::axis_data_t M_AXIS_TDATA,
	output logic                   M_AXIS_TLAST,
	input  logic                   M_AXIS_TREADY
);

	coproc_pkg::a_wr_t     a_wr;
	coproc_pkg::b_wr_t     b_wr;
	coproc_pkg::a_addr_t   a_rd_addr;
	coproc_pkg::b_addr_t   b_rd_addr;
	coproc_pkg::elem_t     a_rd_data;   // A RAM to MAC
	coproc_pkg::elem_t     b_rd_data;   // B RAM to MAC
	coproc_pkg::mac_op_t   mac_op;
	coproc_pkg::res_wr_t   res_wr;      // MAC to RES RAM
	coproc_pkg::res_rd_t   res_rd;      // Controller to RES RAM and streamer
	coproc_pkg::acc_t      res_rd_data;
	logic                  slot_free;

	coproc_ctrl u_ctrl (
		.ACLK         (ACLK),
		.ARESETN      (ARESETN),
		.S_AXIS_TVALID(S_AXIS_TVALID),
		.S_AXIS_TDATA (S_AXIS_TDATA),
		.S_AXIS_TREADY(S_AXIS_TREADY),
		.a_wr         (a_wr),
		.b_wr         (b_wr),
		.a_rd_addr    (a_rd_addr),
		.b_rd_addr    (b_rd_addr),
		.mac_op       (mac_op),
		.res_rd       (res_rd),
		.slot_free    (slot_free)
	);

	matrix_ram #(
		.depth_bits($bits(coproc_pkg::a_addr_t)),
		.width     ($bits(coproc_pkg::elem_t))
	) a_ram (
		.ACLK(ACLK), .wr_en(a_wr.en), .wr_addr(a_wr.addr), .wr_data(a_wr.data),
		.rd_addr(a_rd_addr), .rd_data(a_rd_data)
	);

	matrix_ram #(
		.depth_bits($bits(coproc_pkg::b_addr_t)),
		.width     ($bits(coproc_pkg::elem_t))
	) b_ram (
		.ACLK(ACLK), .wr_en(b_wr.en), .wr_addr(b_wr.addr), .wr_data(b_wr.data),
		.rd_addr(b_rd_addr), .rd_data(b_rd_data)
	);

	// One word per result row
	matrix_ram #(
		.depth_bits($bits(coproc_pkg::res_addr_t)),
		.width     ($bits(coproc_pkg::acc_t))
	) res_ram (
		.ACLK(ACLK), .wr_en(res_wr.en), .wr_addr(res_wr.addr), .wr_data(res_wr.data),
		.rd_addr(res_rd.addr), .rd_data(res_rd_data)
	);

	dot_product_mac u_mac (
		.ACLK(ACLK), .ARESETN(ARESETN), .mac_op(mac_op),
		.a_data(a_rd_data), .b_data(b_rd_data), .res_wr(res_wr)
	);

	result_streamer u_streamer (
		.ACLK         (ACLK),
		.ARESETN      (ARESETN),
		.res_rd       (res_rd),
		.res_data     (res_rd_data),
		.slot_free    (slot_free),
		.M_AXIS_TVALID(M_AXIS_TVALID),
		.M_AXIS_TDATA (M_AXIS_TDATA),
		.M_AXIS_TLAST (M_AXIS_TLAST),
		.M_AXIS_TREADY(M_AXIS_TREADY)
	);

endmodule

`default_nettype wire

// ==== verif/coproc_chk.sv ====
//--------------------
// Stream assertions bound into coproc_top
// Assumes fixed frames of A then B and TLAST on the final result
// fail_cnt is read by the testbench at the end of the run
//--------------------
`timescale 1ns/1ps
`default_nettype none
`include "coproc_defines.svh"

module coproc_chk (
	input logic                   ACLK,
	input logic                   ARESETN,
	input logic                   S_AXIS_TVALID,
	input logic                   S_AXIS_TREADY,
	input logic                   M_AXIS_TVALID,
	input coproc_pkg::axis_data_t M_AXIS_TDATA,
	input logic                   M_AXIS_TLAST,
	input logic                   M_AXIS_TREADY
);

	localparam int frame_len = `COPROC_ROWS * `COPROC_COLS + `COPROC_COLS;

	coproc_pkg::frame_cnt_t s_cnt;         // Input beats of this frame
	coproc_pkg::res_addr_t  m_cnt;         // Output beats of this frame
	int                     fail_cnt = 0;
	logic                   s_xfer;
	logic                   m_xfer;

	assign s_xfer = S_AXIS_TVALID && S_AXIS_TREADY;
	assign m_xfer = M_AXIS_TVALID && M_AXIS_TREADY;

	always_ff @(posedge ACLK) begin
		if (!ARESETN) begin
			s_cnt <= '0;
			m_cnt <= '0;
		end else if (m_xfer && M_AXIS_TLAST) begin
			s_cnt <= '0;  // Frame closed
			m_cnt <= '0;
		end else begin
			if (s_xfer) s_cnt <= s_cnt + 1'b1;
			if (m_xfer) m_cnt <= m_cnt + 1'b1;
		end
	end

	// Both streams quiet straight out of reset
	quiet_after_reset: assert property (@(posedge ACLK)
		!ARESETN |=> !S_AXIS_TREADY && !M_AXIS_TVALID && !M_AXIS_TLAST)
	else begin
		fail_cnt++;
		$error("stream outputs active right after reset");
	end

	// Stalled word held until taken
	hold_under_stall: assert property (@(posedge ACLK) disable iff (!ARESETN)
		M_AXIS_TVALID && !M_AXIS_TREADY |=>
		M_AXIS_TVALID && $stable(M_AXIS_TDATA) && $stable(M_AXIS_TLAST))
	else begin
		fail_cnt++;
		$error("M_AXIS word changed or dropped under back-pressure");
	end

	last_on_eighth: assert property (@(posedge ACLK) disable iff (!ARESETN)
		m_xfer |-> (M_AXIS_TLAST == (m_cnt == coproc_pkg::res_addr_t'(`COPROC_ROWS - 1))))
	else begin
		fail_cnt++;
		$error("M_AXIS_TLAST on the wrong output beat");
	end

	// Full frame stored so no 37th beat
	no_extra_input: assert property (@(posedge ACLK) disable iff (!ARESETN)
		(s_cnt == coproc_pkg::frame_cnt_t'(frame_len)) |-> !S_AXIS_TREADY)
	else begin
		fail_cnt++;
		$error("S_AXIS_TREADY high after a full frame");
	end

endmodule

`default_nettype wire

// ==== verif/coproc_tb.sv ====
//--------------------
// Testbench for coproc_top
// Fixed frames of 36 byte beats, LCG data, input gaps and output stalls
// A spare input beat is held during compute and output of every frame
//--------------------
`timescale 1ns/1ps
`default_nettype none
`include "coproc_defines.svh"

module coproc_tb;

	localparam int clk_period = 4;
	localparam int a_len      = `COPROC_ROWS * `COPROC_COLS;
	localparam int frame_len  = a_len + `COPROC_COLS;
	localparam int frames     = 4;
	// Load, 34 compute cycles, stalled outputs and slack, doubled
	localparam int watchdog_ns =
		frames * (frame_len + a_len + 2 + `COPROC_ROWS * 4 + 40) * clk_period * 2;

	logic                   ACLK;
	logic                   ARESETN;
	logic                   S_AXIS_TVALID;
	coproc_pkg::axis_data_t S_AXIS_TDATA;
	logic                   S_AXIS_TREADY;
	logic                   M_AXIS_TVALID;
	coproc_pkg::axis_data_t M_AXIS_TDATA;
	logic                   M_AXIS_TLAST;
	logic                   M_AXIS_TREADY;

	coproc_pkg::elem_t      a_bytes [a_len];
	coproc_pkg::elem_t      b_bytes [`COPROC_COLS];
	coproc_pkg::axis_data_t expect_res [`COPROC_ROWS];  // Model results of this frame
	logic [31:0]            seed = 32'd17336;
	int                     errors = 0;
	int                     tests_run = 0;
	int                     tests_failed = 0;

	coproc_top DUT (
		.ACLK(ACLK), .ARESETN(ARESETN),
		.S_AXIS_TVALID(S_AXIS_TVALID), .S_AXIS_TDATA(S_AXIS_TDATA),
		.S_AXIS_TREADY(S_AXIS_TREADY), .M_AXIS_TVALID(M_AXIS_TVALID),
		.M_AXIS_TDATA(M_AXIS_TDATA), .M_AXIS_TLAST(M_AXIS_TLAST),
		.M_AXIS_TREADY(M_AXIS_TREADY)
	);

	bind coproc_top coproc_chk u_chk (
		.ACLK(ACLK), .ARESETN(ARESETN),
		.S_AXIS_TVALID(S_AXIS_TVALID), .S_AXIS_TREADY(S_AXIS_TREADY),
		.M_AXIS_TVALID(M_AXIS_TVALID), .M_AXIS_TDATA(M_AXIS_TDATA),
		.M_AXIS_TLAST(M_AXIS_TLAST), .M_AXIS_TREADY(M_AXIS_TREADY)
	);

	initial begin
		ACLK = 1'b0;
		forever #(clk_period / 2) ACLK = ~ACLK;
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// True about pct times in 100
	function automatic bit chance(input int pct);
		logic [31:0] r;
		r = next_rand();
		return (int'(r[30:16]) % 100) < pct;
	endfunction

	task automatic next_cycle();
		@(posedge ACLK);
		#1;  // Drive point
	endtask

	// mode 0 all zero, 1 all 0xFF, else random
	task automatic load_operands(input int mode);
		logic [31:0]            r;
		coproc_pkg::axis_data_t sum;
		for (int i = 0; i < frame_len; i++) begin
			r = next_rand();
			if (mode == 0) r = '0;
			else if (mode == 1) r = '1;
			if (i < a_len) a_bytes[i] = r[31:24];
			else b_bytes[i - a_len] = r[31:24];
		end
		for (int row = 0; row < `COPROC_ROWS; row++) begin
			sum = '0;
			for (int k = 0; k < `COPROC_COLS; k++) begin
				sum = sum + 32'(a_bytes[row * `COPROC_COLS + k]) * 32'(b_bytes[k]);
			end
			expect_res[row] = sum;  // Unsigned row of A times B
		end
	endtask

	task automatic send_frame(input int gap_pct);
		int                idx;
		bit                pending;    // Beat offered and not yet taken
		bit                xfer;
		logic [31:0]       r;
		coproc_pkg::elem_t beat;
		idx = 0;
		pending = 1'b0;
		while (idx < frame_len) begin
			if (!pending && chance(gap_pct)) begin
				S_AXIS_TVALID = 1'b0;
			end else if (!pending) begin
				r = next_rand();
				beat = (idx < a_len) ? a_bytes[idx] : b_bytes[idx - a_len];
				S_AXIS_TVALID = 1'b1;
				S_AXIS_TDATA = {r[23:0], beat};  // Junk above the byte
				pending = 1'b1;
			end
			#2;
			xfer = S_AXIS_TVALID && S_AXIS_TREADY;
			next_cycle();
			if (xfer) begin
				idx++;
				pending = 1'b0;
			end
		end
		S_AXIS_TVALID = 1'b1;  // Spare beat that must not be taken
		S_AXIS_TDATA = next_rand();
	endtask

	task automatic collect_results(input string name, input int stall_pct);
		int got;
		got = 0;
		while (got < `COPROC_ROWS) begin
			M_AXIS_TREADY = !chance(stall_pct);
			#2;
			assert (!S_AXIS_TREADY) else begin
				$display("MISMATCH %s S_AXIS_TREADY got %h expected 0", name, S_AXIS_TREADY);
				errors++;
			end
			if (M_AXIS_TVALID && M_AXIS_TREADY) begin
				assert (M_AXIS_TDATA == expect_res[got]) else begin
					$display("MISMATCH %s row %0d M_AXIS_TDATA got %h expected %h",
						name, got, M_AXIS_TDATA, expect_res[got]);
					errors++;
				end
				assert (M_AXIS_TLAST == (got == `COPROC_ROWS - 1)) else begin
					$display("MISMATCH %s row %0d M_AXIS_TLAST got %h expected %h",
						name, got, M_AXIS_TLAST, got == `COPROC_ROWS - 1);
					errors++;
				end
				got++;
			end
			next_cycle();
		end
		S_AXIS_TVALID = 1'b0;
		M_AXIS_TREADY = 1'b1;
		repeat (2) begin
			#2;
			assert (!M_AXIS_TVALID) else begin
				$display("%s sent an extra output word after TLAST", name);
				errors++;
			end
			next_cycle();
		end
	endtask

	task automatic report_test(input string name, input int start_err);
		tests_run++;
		if (errors > start_err) begin
			tests_failed++;
			$display("test %s: FAIL with %0d errors", name, errors - start_err);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	task automatic run_frame(input string name, input int mode, input int gap_pct,
		input int stall_pct);
		int start_err;
		start_err = errors;
		load_operands(mode);
		send_frame(gap_pct);
		collect_results(name, stall_pct);
		report_test(name, start_err);
	endtask

	initial begin
		ARESETN = 1'b0;
		S_AXIS_TVALID = 1'b0;
		S_AXIS_TDATA = '0;
		M_AXIS_TREADY = 1'b0;
		repeat (10) @(posedge ACLK);
		#1;
		ARESETN = 1'b1;
		#2;
		assert (!S_AXIS_TREADY && !M_AXIS_TVALID) else begin
			$display("MISMATCH S_AXIS_TREADY got %h M_AXIS_TVALID got %h expected 0 after reset",
				S_AXIS_TREADY, M_AXIS_TVALID);
			errors++;
		end
		report_test("reset", 0);
		next_cycle();
		run_frame("zero_frame", 0, 0, 0);
		run_frame("max_frame", 1, 0, 0);
		run_frame("random_gaps_stalls", 2, 30, 40);
		run_frame("back_to_back", 2, 0, 25);  // Follows directly with no reset
		$display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
			tests_run, tests_failed, errors, DUT.u_chk.fail_cnt);
		if (errors == 0 && DUT.u_chk.fail_cnt == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(watchdog_ns);
		$display("Timeout: run did not finish within %0d ns", watchdog_ns);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+src
src/coproc_pkg.sv
src/matrix_ram.sv
src/dot_product_mac.sv
src/result_streamer.sv
src/coproc_ctrl.sv
src/coproc_top.sv
verif/coproc_chk.sv
verif/coproc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the coprocessor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module coproc_tb -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vcoproc_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
	exit 0
fi
echo "Simulation did not report a pass"
exit 1
